/* source/row_pkg.sv */
// ####################
// Row interconnect package
// Widths, counts and the packed types shared by
// the context memory, sequencer and crossbar
// ####################

`default_nettype none

package row_pkg;

	// Data path
	localparam int WORD_BITS = 32;
	localparam int PE_COUNT = 4; // PEs in one row
	localparam int LANES = 4; // Words per group and PE

	// Context memory
	localparam int UNIT_BITS = 4; // Unit field of a write address
	localparam int CTX_ADDR_BITS = 5;
	localparam int CTX_DEPTH = 32;

	// Selector widths per output group
	localparam int D48_SEL_BITS = 6;
	localparam int B16_SEL_BITS = 4;
	localparam int B8_SEL_BITS = 3;

	// Finish delay line taps
	localparam int IDLE_TAP = 7; // Run ends here
	localparam int CLEAR_TAP = 9; // Outputs cleared here

	typedef logic [WORD_BITS-1:0] word_t;
	typedef logic [CTX_ADDR_BITS-1:0] ctx_addr_t;

	// Source words offered by one PE
	typedef struct packed {
		word_t [LANES-1:0] s48; // ALU side
		word_t [LANES-1:0] b16;
		word_t [LANES-1:0] b8;
	} pe_src_t;

	typedef pe_src_t [PE_COUNT-1:0] row_src_t;

	// Registered outputs of the row block
	typedef struct packed {
		word_t [LANES-1:0] d48; // ALU operands
		word_t [LANES-1:0] b16; // 16-to-1 buffers
		word_t [LANES-1:0] b8; // 8-to-1 buffers
	} row_dst_t;

	// One routing word, 52 bits
	// Lane 0 of each field sits in the upper bits, b8 lane 3 ends at bit 0
	typedef struct packed {
		logic [0:LANES-1][D48_SEL_BITS-1:0] d48_sel;
		logic [0:LANES-1][B16_SEL_BITS-1:0] b16_sel;
		logic [0:LANES-1][B8_SEL_BITS-1:0] b8_sel;
	} ctx_word_t;

	// Context write request from outside
	typedef struct packed {
		logic en;
		logic we;
		logic [UNIT_BITS-1:0] unit; // Target unit number
		ctx_addr_t addr;
		ctx_word_t data;
	} ctx_wr_t;

endpackage

`default_nettype wire

/* source/ctx_ram.sv */
// ####################
// Context memory
// Simple dual-port RAM, one write port and
// one registered read port
// ####################

`timescale 1ns/1ns
`default_nettype none

module ctx_ram (
	input wire logic CLK,
	input wire logic RST,
	input wire logic wr_hit,
	input wire row_pkg::ctx_addr_t wr_addr,
	input wire row_pkg::ctx_word_t wr_data,
	input wire logic rd_en,
	input wire row_pkg::ctx_addr_t rd_addr,
	output row_pkg::ctx_word_t rd_data
);

	row_pkg::ctx_word_t mem [row_pkg::CTX_DEPTH];

	// Write port
	always_ff @(posedge CLK) begin
		if (wr_hit) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Read data holds while rd_en is low
	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			rd_data <= '0;
		end else if (rd_en) begin
			rd_data <= mem[rd_addr]; // Old word on a same-edge write
		end
	end

endmodule

`default_nettype wire

/* source/ctx_sequencer.sv */
// ####################
// Context sequencer
// Run state, context read address, end
// detection and the finish delay line
// ####################

`timescale 1ns/1ns
`default_nettype none

module ctx_sequencer (
	input wire logic CLK,
	input wire logic RST,
	input wire logic start,
	input wire logic incr,
	input wire logic wr_hit,
	input wire row_pkg::ctx_addr_t wr_addr,
	output logic rd_en,
	output row_pkg::ctx_addr_t rd_addr,
	output logic clear,
	output logic busy
);

	typedef enum logic {
		ST_IDLE,
		ST_RUN
	} state_t;

	state_t state;
	row_pkg::ctx_addr_t end_addr; // Last address written to this unit
	logic [row_pkg::CLEAR_TAP:1] fin; // Finish stages

	assign busy = (state == ST_RUN);
	assign rd_en = busy; // One context read per busy cycle
	assign clear = fin[row_pkg::CLEAR_TAP];

	// End marker follows the latest write hit
	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			end_addr <= '0;
		end else if (wr_hit) begin
			end_addr <= wr_addr;
		end
	end

	// Run machine
	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (start) begin
						state <= ST_RUN;
					end
				end
				ST_RUN: begin
					if (fin[row_pkg::IDLE_TAP]) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Read address, steps by incr and wraps naturally
	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			rd_addr <= '0;
		end else if (!busy || fin[row_pkg::IDLE_TAP]) begin
			rd_addr <= '0;
		end else begin
			rd_addr <= rd_addr + row_pkg::ctx_addr_t'(incr);
		end
	end

	// Finish delay line
	// Stage 1 latches the end hit and holds until the machine is idle
	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			fin <= '0;
		end else begin
			fin[row_pkg::CLEAR_TAP:2] <= fin[row_pkg::CLEAR_TAP-1:1];
			if (!busy) begin
				fin[1] <= 1'b0;
			end else if (rd_addr == end_addr) begin
				fin[1] <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* source/row_crossbar.sv */
// ####################
// Row crossbar
// Twelve selectors over the PE source words,
// registered outputs with a clear strobe
// ####################

`timescale 1ns/1ns
`default_nettype none

module row_crossbar (
	input wire logic CLK,
	input wire logic RST,
	input wire row_pkg::ctx_word_t sel,
	input wire row_pkg::row_src_t src,
	input wire logic clear,
	output row_pkg::row_dst_t dst
);

	// Each PE flattened as s48 0-3, b16 0-3, b8 0-3
	row_pkg::word_t pe_words [row_pkg::PE_COUNT][3*row_pkg::LANES];

	row_pkg::word_t d48_pool [2**row_pkg::D48_SEL_BITS];
	row_pkg::word_t b16_pool [2**row_pkg::B16_SEL_BITS];
	row_pkg::word_t b8_pool [2**row_pkg::B8_SEL_BITS];

	row_pkg::row_dst_t dst_nxt;

	always_comb begin
		for (int p = 0; p < row_pkg::PE_COUNT; p++) begin
			for (int l = 0; l < row_pkg::LANES; l++) begin
				pe_words[p][l] = src[p].s48[l];
				pe_words[p][row_pkg::LANES+l] = src[p].b16[l];
				pe_words[p][2*row_pkg::LANES+l] = src[p].b8[l];
			end
		end
	end

	always_comb begin
		// Codes past the 48 words give zero
		for (int i = 0; i < 2**row_pkg::D48_SEL_BITS; i++) begin
			d48_pool[i] = '0;
		end
		// PE-major order over the whole row
		for (int p = 0; p < row_pkg::PE_COUNT; p++) begin
			for (int k = 0; k < 3*row_pkg::LANES; k++) begin
				d48_pool[p*3*row_pkg::LANES+k] = pe_words[p][k];
			end
		end

		// Last PE's twelve words, then PE0 s48
		for (int k = 0; k < 3*row_pkg::LANES; k++) begin
			b16_pool[k] = pe_words[row_pkg::PE_COUNT-1][k];
		end
		for (int l = 0; l < row_pkg::LANES; l++) begin
			b16_pool[3*row_pkg::LANES+l] = pe_words[0][l];
		end

		// Last PE's b16 and b8 words
		for (int k = 0; k < 2*row_pkg::LANES; k++) begin
			b8_pool[k] = pe_words[row_pkg::PE_COUNT-1][row_pkg::LANES+k];
		end
	end

	// Lane selection
	always_comb begin
		for (int l = 0; l < row_pkg::LANES; l++) begin
			dst_nxt.d48[l] = d48_pool[sel.d48_sel[l]];
			dst_nxt.b16[l] = b16_pool[sel.b16_sel[l]];
			dst_nxt.b8[l] = b8_pool[sel.b8_sel[l]];
		end
	end

	// One cycle from src and sel to dst
	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			dst <= '0;
		end else if (clear) begin
			dst <= '0; // End of run
		end else begin
			dst <= dst_nxt;
		end
	end

endmodule

`default_nettype wire

/* source/row_connection.sv */
// ####################
// Row connection block
// Context-driven routing of the row's PE words
// onto ALU operands and buffer inputs
// ####################

`timescale 1ns/1ns
`default_nettype none

module row_connection #(
	parameter logic [row_pkg::UNIT_BITS-1:0] unit_no = '0
) (
	input wire logic CLK,
	input wire logic RST,
	input wire row_pkg::ctx_wr_t ctx_wr,
	input wire logic start,
	input wire logic incr,
	input wire row_pkg::row_src_t src,
	output row_pkg::row_dst_t dst,
	output logic busy
);

	logic wr_hit;
	logic rd_en;
	logic clear;
	row_pkg::ctx_addr_t rd_addr;
	row_pkg::ctx_word_t rd_data;

	// Only writes addressed to this unit reach the memory and end marker
	assign wr_hit = ctx_wr.en & ctx_wr.we & (ctx_wr.unit == unit_no);

	ctx_ram u_ram (
		.CLK(CLK),
		.RST(RST),
		.wr_hit(wr_hit),
		.wr_addr(ctx_wr.addr),
		.wr_data(ctx_wr.data),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

	ctx_sequencer u_seq (
		.CLK(CLK),
		.RST(RST),
		.start(start),
		.incr(incr),
		.wr_hit(wr_hit),
		.wr_addr(ctx_wr.addr),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.clear(clear),
		.busy(busy)
	);

	// Routing word comes straight from the RAM read register
	row_crossbar u_xbar (
		.CLK(CLK),
		.RST(RST),
		.sel(rd_data),
		.src(src),
		.clear(clear),
		.dst(dst)
	);

endmodule

`default_nettype wire

/* sim/row_connection_chk.sv */
// ####################
// Row connection checker
// Bound assertions on reset, output
// clearing and context read data
// ####################

`timescale 1ns/1ns
`default_nettype none

module row_connection_chk (
	input wire logic CLK,
	input wire logic RST,
	input wire logic busy,
	input wire logic clear,
	input wire row_pkg::ctx_word_t rd_data,
	input wire row_pkg::row_dst_t dst
);

	// No run while reset is held
	reset_idle: assert property (@(posedge CLK) !RST |-> !busy)
		else $error("busy high while RST is low");

	// Outputs zero one edge after clear
	clear_zero: assert property (@(posedge CLK) disable iff (!RST)
		clear |=> (dst == '0))
		else $error("dst not zero after clear");

	// Context reads only happen in busy cycles
	idle_read_hold: assert property (@(posedge CLK) disable iff (!RST)
		!busy |=> $stable(rd_data))
		else $error("context read data changed while not busy");

endmodule

bind row_connection row_connection_chk u_chk (
	.CLK(CLK),
	.RST(RST),
	.busy(busy),
	.clear(clear),
	.rd_data(rd_data),
	.dst(dst)
);

`default_nettype wire

/* sim/row_connection_tb.sv */
// ####################
// Row connection testbench
// Random context words and source words,
// checked every cycle against a cycle model
// ####################

`timescale 1ns/1ns
`default_nettype none

module row_connection_tb;

	localparam logic [row_pkg::UNIT_BITS-1:0] UNIT_NO = 4'd3;
	localparam int WORDS_PER_PE = 3 * row_pkg::LANES;
	localparam int D48_WORDS = row_pkg::PE_COUNT * WORDS_PER_PE;
	localparam int RUNS = 10;
	localparam int GAP = 10; // Idle cycles before each start
	localparam int HOLD = 20; // incr held low this long in the long run
	localparam int RUN_LIMIT = 2 * row_pkg::CTX_DEPTH + HOLD + 16;
	localparam int WATCHDOG_CYCLES = RUNS * (row_pkg::CTX_DEPTH + 12) + 200;

	logic CLK = 1'b0;
	logic RST = 1'b0;
	row_pkg::ctx_wr_t ctx_wr;
	logic start;
	logic incr;
	row_pkg::row_src_t src;
	row_pkg::row_dst_t dst;
	logic busy;

	integer seed = 32'h93b8a4c4;
	logic stopped = 1'b0; // A final message is already out
	logic timed_out = 1'b0;

	// Model state
	logic m_busy = 1'b0;
	row_pkg::ctx_addr_t m_addr = '0;
	row_pkg::ctx_addr_t m_end = '0;
	logic [row_pkg::CLEAR_TAP:1] m_fin = '0;
	row_pkg::ctx_word_t m_rd = '0;
	row_pkg::row_dst_t m_dst = '0;
	row_pkg::ctx_word_t m_mem [row_pkg::CTX_DEPTH];

	row_connection #(
		.unit_no(UNIT_NO)
	) dut (
		.CLK(CLK),
		.RST(RST),
		.ctx_wr(ctx_wr),
		.start(start),
		.incr(incr),
		.src(src),
		.dst(dst),
		.busy(busy)
	);

	always #5 CLK = ~CLK;

	function automatic logic [31:0] next_random();
		return $random(seed);
	endfunction

	function automatic row_pkg::ctx_word_t random_ctx_word();
		logic [63:0] bits;
		bits = {next_random(), next_random()};
		return bits[$bits(row_pkg::ctx_word_t)-1:0];
	endfunction

	// Word k of one PE, ordered s48, b16, b8
	function automatic row_pkg::word_t pe_word(input row_pkg::row_src_t s, input int pe,
			input int k);
		if (k < row_pkg::LANES) begin
			return s[pe].s48[k];
		end else if (k < 2 * row_pkg::LANES) begin
			return s[pe].b16[k - row_pkg::LANES];
		end
		return s[pe].b8[k - 2 * row_pkg::LANES];
	endfunction

	// Expected outputs for one routing word
	function automatic row_pkg::row_dst_t route(input row_pkg::ctx_word_t w,
			input row_pkg::row_src_t s);
		row_pkg::row_dst_t r;
		int v;
		for (int l = 0; l < row_pkg::LANES; l++) begin
			v = int'(w.d48_sel[l]);
			if (v < D48_WORDS) begin
				r.d48[l] = pe_word(s, v / WORDS_PER_PE, v % WORDS_PER_PE);
			end else begin
				r.d48[l] = '0; // Codes 48 to 63
			end
			v = int'(w.b16_sel[l]);
			if (v < WORDS_PER_PE) begin
				r.b16[l] = pe_word(s, row_pkg::PE_COUNT - 1, v);
			end else begin
				r.b16[l] = pe_word(s, 0, v - WORDS_PER_PE);
			end
			v = int'(w.b8_sel[l]);
			r.b8[l] = pe_word(s, row_pkg::PE_COUNT - 1, row_pkg::LANES + v);
		end
		return r;
	endfunction

	// One rising edge of the model, inputs as driven before it
	task automatic model_edge();
		logic hit;
		logic n_busy;
		row_pkg::ctx_addr_t n_addr;
		logic [row_pkg::CLEAR_TAP:1] n_fin;
		row_pkg::ctx_word_t n_rd;
		row_pkg::row_dst_t n_dst;
		if (!RST) begin
			m_busy = 1'b0;
			m_addr = '0;
			m_end = '0;
			m_fin = '0;
			m_rd = '0;
			m_dst = '0;
		end else begin
			hit = ctx_wr.en && ctx_wr.we && (ctx_wr.unit == UNIT_NO);
			n_busy = m_busy;
			if (!m_busy && start) begin
				n_busy = 1'b1;
			end else if (m_busy && m_fin[row_pkg::IDLE_TAP]) begin
				n_busy = 1'b0;
			end
			n_addr = m_addr + row_pkg::ctx_addr_t'(incr); // Wraps at 32
			if (!m_busy || m_fin[row_pkg::IDLE_TAP]) begin
				n_addr = '0;
			end
			n_fin = {m_fin[row_pkg::CLEAR_TAP-1:1], 1'b0};
			n_fin[1] = m_busy && (m_fin[1] || (m_addr == m_end));
			n_rd = m_busy ? m_mem[m_addr] : m_rd;
			n_dst = m_fin[row_pkg::CLEAR_TAP] ? '0 : route(m_rd, src);
			if (hit) begin
				m_mem[ctx_wr.addr] = ctx_wr.data;
				m_end = ctx_wr.addr;
			end
			m_busy = n_busy;
			m_addr = n_addr;
			m_fin = n_fin;
			m_rd = n_rd;
			m_dst = n_dst;
		end
	endtask

	task automatic check_dst(input row_pkg::row_dst_t got, input row_pkg::row_dst_t exp);
		if (got !== exp) begin
			$display("Fail at %0t ns: dst = %h, expected %h", $time, got, exp);
			stopped = 1'b1;
			$display("tests failed");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	task automatic check_busy(input logic got, input logic exp);
		if (got !== exp) begin
			$display("Fail at %0t ns: busy = %b, expected %b", $time, got, exp);
			stopped = 1'b1;
			$display("tests failed");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	// Model and DUT take one edge, compare at the falling edge
	task automatic step();
		@(posedge CLK);
		model_edge();
		@(negedge CLK);
		check_busy(busy, m_busy);
		check_dst(dst, m_dst);
	endtask

	task automatic drive_random_src();
		for (int p = 0; p < row_pkg::PE_COUNT; p++) begin
			for (int l = 0; l < row_pkg::LANES; l++) begin
				src[p].s48[l] = next_random();
				src[p].b16[l] = next_random();
				src[p].b8[l] = next_random();
			end
		end
	endtask

	task automatic drive_write(input logic [row_pkg::UNIT_BITS-1:0] unit,
			input row_pkg::ctx_addr_t addr);
		ctx_wr.en = 1'b1;
		ctx_wr.we = 1'b1;
		ctx_wr.unit = unit;
		ctx_wr.addr = addr;
		ctx_wr.data = random_ctx_word();
	endtask

	task automatic drive_foreign_write();
		logic [31:0] rv;
		rv = next_random();
		drive_write((rv[3:0] == UNIT_NO) ? rv[3:0] + 4'd1 : rv[3:0], rv[8:4]);
	endtask

	// Any unit, en and we random, this unit favored
	task automatic drive_random_write();
		logic [31:0] rv;
		rv = next_random();
		ctx_wr.en = rv[0];
		ctx_wr.we = rv[1];
		ctx_wr.unit = rv[2] ? UNIT_NO : rv[7:4];
		ctx_wr.addr = rv[12:8];
		ctx_wr.data = random_ctx_word();
	endtask

	// Writes while idle, then one run until busy falls
	task automatic run_once(input int r);
		logic [31:0] rv;
		logic zero_end;
		logic long_hold;
		int cycles;
		zero_end = (r % 3) == 1; // incr low, end address 0
		long_hold = (r == 2); // incr low for a while, end elsewhere
		start = 1'b0;
		incr = 1'b0;
		for (int g = 0; g < GAP; g++) begin
			drive_random_write();
			if (g == GAP - 1 && zero_end) begin
				drive_write(UNIT_NO, '0);
			end else if (g == GAP - 1 && long_hold) begin
				rv = next_random();
				drive_write(UNIT_NO, row_pkg::ctx_addr_t'(1 + rv % 31));
			end
			if (r > 0) begin
				drive_random_src(); // Sources stay zero before the first run
			end
			step();
		end
		ctx_wr = '0;
		start = 1'b1;
		incr = !long_hold && !zero_end;
		drive_random_src();
		step();
		cycles = 0;
		while (busy) begin
			rv = next_random();
			start = rv[0]; // Ignored while busy
			if (long_hold) begin
				incr = (cycles >= HOLD);
			end
			drive_random_src();
			step();
			cycles++;
			if (cycles > RUN_LIMIT) begin
				stopped = 1'b1;
				$display("run %0d did not finish within %0d cycles", r, RUN_LIMIT);
				$display("tests failed");
				$fatal(1, "run did not end");
			end
		end
	endtask

	initial begin
		ctx_wr = '0;
		start = 1'b0;
		incr = 1'b0;
		src = '0;
		repeat (2) step();
		RST = 1'b1;
		// Every address of this unit gets a word, other units mixed in
		for (int a = 0; a < row_pkg::CTX_DEPTH; a++) begin
			drive_write(UNIT_NO, row_pkg::ctx_addr_t'(a));
			step();
			if ((a % 4) == 3) begin
				drive_foreign_write();
				step();
			end
		end
		for (int r = 0; r < RUNS; r++) begin
			run_once(r);
		end
		start = 1'b0;
		incr = 1'b0;
		ctx_wr = '0;
		repeat (GAP + 2) begin
			drive_random_src();
			step();
		end
		stopped = 1'b1;
		$display("all tests passed");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK);
		timed_out = 1'b1;
		$display("watchdog expired after %0d cycles, simulation stopped", WATCHDOG_CYCLES);
		$display("tests failed");
		$fatal(1, "watchdog timeout");
	end

	final begin
		if (!stopped && !timed_out) begin
			$display("tests failed"); // Run ended before the last check
		end
	end

endmodule

`default_nettype wire

/* list.f */
source/row_pkg.sv
source/ctx_ram.sv
source/ctx_sequencer.sv
source/row_crossbar.sv
source/row_connection.sv
sim/row_connection_chk.sv
sim/row_connection_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the row connection testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module row_connection_tb \
	-Mdir obj_dir \
	-f list.f

out=$(./obj_dir/Vrow_connection_tb 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "all tests passed"; then
	exit 0
else
	exit 1
fi
